// ==== Bender.yml ====
package:
  name: uart_top

sources:
  - common/uart_pkg.sv
  - logic/baud_gen.sv
  - uart_rx/uart_rx.sv
  - uart_tx/uart_tx.sv
  - logic/rx_fifo.sv
  - logic/uart_cfg.sv
  - logic/uart_top.sv
  - target: test
    files:
      - bench/uart_top_assertions.sv
      - bench/uart_top_tb.sv

// ==== bench/uart_top_assertions.sv ====
`timescale 1ns/100ps

module uart_top_assertions (
  input logic               clk,
  input logic               rst_n,
  input logic               tx_valid,
  input logic               tx_ready,
  input uart_pkg::data_t    tx_data,
  input logic               txd,
  input logic               rx_valid,
  input logic               rx_ready,
  input uart_pkg::rx_word_t rx_word
);

  int fail_count = 0;  // failed properties so far

  // sender holds its byte under back-pressure
  tx_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
    tx_valid && !tx_ready |=> $stable(tx_data))
    else begin
      $error("tx_data changed while waiting for tx_ready");
      fail_count++;
    end

  rx_word_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rx_valid && !rx_ready |=> $stable(rx_word))
    else begin
      $error("rx_word changed while rx_ready was low");
      fail_count++;
    end

  // line idles high whenever the transmitter can take a byte
  txd_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    tx_ready |-> txd)
    else begin
      $error("txd low while tx_ready high");
      fail_count++;
    end

  rx_valid_reset: assert property (@(posedge clk) !rst_n |=> !rx_valid)
    else begin
      $error("rx_valid high after a reset cycle");
      fail_count++;
    end

endmodule

bind uart_top uart_top_assertions u_assert (
  .clk      (clk),
  .rst_n    (rst_n),
  .tx_valid (tx_valid),
  .tx_ready (tx_ready),
  .tx_data  (tx_data),
  .txd      (txd),
  .rx_valid (rx_valid),
  .rx_ready (rx_ready),
  .rx_word  (rx_word)
);

// ==== bench/uart_top_tb.sv ====
`timescale 1ns/100ps

module uart_top_tb;
  import uart_pkg::*;

  localparam baud_inc_t BAUD_FAST = 24'h40_0000;  // 2**22
  localparam int CPB_SLOW = (OVERSAMPLE << 24) / int'(BAUD_RESET);
  localparam int CPB_FAST = (OVERSAMPLE << 24) / int'(BAUD_FAST);

  localparam int N_RX  = 40;
  localparam int N_ERR = 6;
  localparam int N_OVR = 6;
  localparam int N_TX  = 30;

  // watchdog budget per frame counts gaps and drains as extra bits
  localparam int FRAMES_SLOW  = N_RX + N_ERR + N_OVR + N_TX;
  localparam int FRAMES_FAST  = N_RX + N_TX;
  localparam int GAP_BITS     = 3;
  localparam int WATCHDOG_CYC = FRAMES_SLOW * (DATA_BITS + 2 + GAP_BITS) * CPB_SLOW
                              + FRAMES_FAST * (DATA_BITS + 3 + GAP_BITS) * CPB_FAST
                              + 20000;

  logic      clk;
  logic      rst_n;
  logic      cfg_valid;
  logic      cfg_ready;
  cfg_wr_t   cfg_wr;
  logic      tx_valid;
  logic      tx_ready;
  data_t     tx_data;
  logic      txd;
  logic      rxd;
  logic      rx_valid;
  logic      rx_ready;
  rx_word_t  rx_word;
  logic      frame_err_flag;
  logic      overrun_flag;

  int        cpb;             // clocks per bit at the current increment
  logic      stop_two_mode;
  logic      hold_ready_low;
  rx_word_t  rx_exp[$];       // words sent on rxd in send order
  data_t     tx_exp[$];       // bytes accepted on the transmit side

  uart_top uut (.*);

  always #2 clk = ~clk;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_rx_word(input rx_word_t exp, input rx_word_t act);
    if (act !== exp) begin
      report_error($sformatf("MISMATCH rx_word expected %h actual %h", exp, act));
    end
  endtask

  task automatic check_data(input data_t exp, input data_t act);
    if (act !== exp) begin
      report_error($sformatf("MISMATCH txd data expected %h actual %h", exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  // every driver and sampler works 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic cfg_write(input cfg_addr_t waddr, input cfg_data_t wdata);
    cfg_valid = 1'b1;
    cfg_wr    = '{addr: waddr, data: wdata};
    if (!cfg_ready) begin
      report_error("cfg_ready was low while a configuration write was offered");
    end
    next_cycle();
    cfg_valid = 1'b0;
  endtask

  task automatic drive_rx_bit(input logic v);
    rxd = v;
    repeat (cpb) next_cycle();
  endtask

  task automatic send_rx_frame(input data_t d, input logic bad);
    int b;
    int gap;
    drive_rx_bit(1'b0);  // start
    for (b = 0; b < DATA_BITS; b++) begin
      drive_rx_bit(d[b]);
    end
    if (stop_two_mode) begin
      drive_rx_bit(1'b1);
    end
    drive_rx_bit(!bad);  // last stop bit
    rxd = 1'b1;
    // a low stop needs an idle bit before the next start edge
    gap = int'($urandom % (cpb / 2)) + (bad ? cpb : 0);
    repeat (gap) next_cycle();
  endtask

  task automatic rx_burst(input int n, input int bad_pct, input int keep);
    data_t d;
    logic  bad;
    int    i;
    for (i = 0; i < n; i++) begin
      d   = data_t'($urandom);
      bad = (bad_pct > 0) && ((i == 0) || (int'($urandom % 100) < bad_pct));
      if (i < keep) begin
        rx_exp.push_back(rx_word_t'{data: d, frame_err: bad});
      end
      send_rx_frame(d, bad);
    end
  endtask

  task automatic wait_rx_drain();
    int n;
    n = 0;
    while (rx_exp.size() > 0) begin
      if (n > 16 * cpb) begin
        report_error("received words never appeared on rx_word");
      end
      next_cycle();
      n++;
    end
    next_cycle();
    check_flag("rx_valid", 1'b0, rx_valid);
  endtask

  task automatic send_tx_byte(input data_t d);
    int n;
    tx_valid = 1'b1;
    tx_data  = d;
    n        = 0;
    while (!tx_ready) begin  // hold data under back-pressure
      if (n > 16 * cpb) begin
        report_error("tx_ready did not return while a byte was offered");
      end
      next_cycle();
      n++;
    end
    tx_exp.push_back(d);
    next_cycle();
    tx_valid = 1'b0;
  endtask

  task automatic tx_burst(input int n);
    int i;
    int w;
    for (i = 0; i < n; i++) begin
      repeat ($urandom % cpb) next_cycle();
      send_tx_byte(data_t'($urandom));
    end
    w = 0;
    while (tx_exp.size() > 0 || !tx_ready) begin
      if (w > 16 * cpb) begin
        report_error("offered bytes never appeared on txd");
      end
      next_cycle();
      w++;
    end
  endtask

  initial begin : rx_collector
    wait (rst_n === 1'b1);
    forever begin
      next_cycle();
      rx_ready = hold_ready_low ? 1'b0 : 1'($urandom % 2);
      if (rx_valid && rx_ready) begin
        if (rx_exp.size() == 0) begin
          report_error("a word appeared on rx_word that was never sent");
        end else begin
          check_rx_word(rx_exp.pop_front(), rx_word);
        end
      end
    end
  end

  initial begin : txd_monitor
    logic  prev;
    data_t d;
    int    b;
    prev = 1'b1;
    wait (rst_n === 1'b1);
    forever begin
      next_cycle();
      if (prev && !txd) begin
        repeat (cpb / 2) next_cycle();  // middle of start bit
        check_flag("txd start bit", 1'b0, txd);
        for (b = 0; b < DATA_BITS; b++) begin
          repeat (cpb) next_cycle();
          d[b] = txd;
        end
        repeat (cpb) next_cycle();
        check_flag("txd stop bit", 1'b1, txd);
        if (stop_two_mode) begin
          repeat (cpb) next_cycle();
          check_flag("txd second stop bit", 1'b1, txd);
        end
        if (tx_exp.size() == 0) begin
          report_error("a byte appeared on txd that was never offered");
        end else begin
          check_data(tx_exp.pop_front(), d);
        end
      end
      prev = txd;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge clk);
    report_error($sformatf("timeout, the run did not finish in %0d cycles", WATCHDOG_CYC));
  end

  initial begin : main_seq
    clk            = 1'b0;
    rst_n          = 1'b0;
    cfg_valid      = 1'b0;
    cfg_wr         = '0;
    tx_valid       = 1'b0;
    tx_data        = '0;
    rxd            = 1'b1;
    rx_ready       = 1'b0;
    cpb            = CPB_SLOW;
    stop_two_mode  = 1'b0;
    hold_ready_low = 1'b0;
    void'($urandom(61));

    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    check_flag("txd", 1'b1, txd);
    check_flag("tx_ready", 1'b1, tx_ready);
    check_flag("rx_valid", 1'b0, rx_valid);
    check_flag("frame_err_flag", 1'b0, frame_err_flag);
    check_flag("overrun_flag", 1'b0, overrun_flag);

    // clean frames at the reset rate
    rx_burst(N_RX, 0, N_RX);
    wait_rx_drain();
    check_flag("frame_err_flag", 1'b0, frame_err_flag);
    check_flag("overrun_flag", 1'b0, overrun_flag);

    // low stop bits, then clear the sticky flag
    rx_burst(N_ERR, 50, N_ERR);
    wait_rx_drain();
    check_flag("frame_err_flag", 1'b1, frame_err_flag);
    cfg_write(ADDR_CTRL, cfg_data_t'(1 << CTRL_CLEAR));
    check_flag("frame_err_flag", 1'b0, frame_err_flag);

    // queue fills with nobody reading
    hold_ready_low = 1'b1;
    rx_burst(N_OVR, 0, FIFO_DEPTH);
    check_flag("overrun_flag", 1'b1, overrun_flag);
    check_flag("rx_valid", 1'b1, rx_valid);
    hold_ready_low = 1'b0;
    wait_rx_drain();
    cfg_write(ADDR_CTRL, cfg_data_t'(1 << CTRL_CLEAR));
    check_flag("overrun_flag", 1'b0, overrun_flag);

    tx_burst(N_TX);

    // double rate with two stop bits
    cfg_write(ADDR_BAUD, cfg_data_t'(BAUD_FAST));
    cfg_write(ADDR_CTRL, cfg_data_t'(1 << CTRL_STOP_TWO));
    cpb           = CPB_FAST;
    stop_two_mode = 1'b1;
    repeat (8) next_cycle();
    rx_burst(N_RX, 15, N_RX);
    wait_rx_drain();
    check_flag("frame_err_flag", 1'b1, frame_err_flag);
    tx_burst(N_TX);

    repeat (cpb) next_cycle();
    if (uut.u_assert.fail_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      report_error("protocol assertions reported errors during the run");
    end
  end

endmodule

// ==== common/uart_pkg.sv ====
package uart_pkg;

  // frame format
  localparam int DATA_BITS  = 8;
  localparam int OVERSAMPLE = 16;   // ticks per bit

  // character and baud types
  typedef logic [DATA_BITS-1:0] data_t;
  typedef logic [23:0]          baud_inc_t;  // tick rate = f_clk * inc / 2**24

  // configuration port
  typedef logic [1:0]  cfg_addr_t;
  typedef logic [23:0] cfg_data_t;

  localparam cfg_addr_t ADDR_BAUD = 2'd0;  // data is the baud increment
  localparam cfg_addr_t ADDR_CTRL = 2'd1;  // control bits below

  // control register bit positions
  localparam int CTRL_STOP_TWO = 0;
  localparam int CTRL_CLEAR    = 1;  // write one to clear both sticky flags

  // 2**21, one tick every 8 clocks, 128 clocks per bit
  localparam baud_inc_t BAUD_RESET = 24'h20_0000;

  // receive queue
  localparam int FIFO_DEPTH = 4;

  typedef struct packed {
    cfg_addr_t addr;
    cfg_data_t data;
  } cfg_wr_t;

  typedef struct packed {
    data_t data;
    logic  frame_err;  // some stop bit sampled low
  } rx_word_t;

endpackage

// ==== logic/baud_gen.sv ====
`timescale 1ns/100ps

module baud_gen (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_pkg::baud_inc_t baud_inc,
  output logic                tick
);
  import uart_pkg::*;

  localparam int PHASE_W = $bits(baud_inc_t);

  baud_inc_t          phase;
  logic [PHASE_W:0]   sum;  // extra bit holds the carry

  assign sum = {1'b0, phase} + {1'b0, baud_inc};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= '0;
      tick  <= 1'b0;
    end else begin
      phase <= sum[PHASE_W-1:0];
      tick  <= sum[PHASE_W];  // carry out, one clock wide
    end
  end

endmodule

// ==== logic/rx_fifo.sv ====
`timescale 1ns/100ps

module rx_fifo (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rx_push,
  input  uart_pkg::rx_word_t push_word,
  output logic               rx_valid,
  input  logic               rx_ready,
  output uart_pkg::rx_word_t rx_word,
  output logic               overrun
);
  import uart_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  rx_word_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             pop;
  logic             push_ok;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full     = (count == CNT_W'(FIFO_DEPTH));
  assign rx_valid = (count != '0);
  assign rx_word  = mem[rd_ptr];
  assign pop      = rx_valid & rx_ready;
  assign push_ok  = rx_push & (~full | pop);  // a pop frees a slot first
  assign overrun  = rx_push & ~push_ok;       // new word dropped

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_word;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push_ok, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== logic/uart_cfg.sv ====
`timescale 1ns/100ps

module uart_cfg (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cfg_valid,
  output logic                cfg_ready,
  input  uart_pkg::cfg_wr_t   cfg_wr,
  input  logic                frame_err_pulse,
  input  logic                overrun,
  output uart_pkg::baud_inc_t baud_inc,
  output logic                stop_two,
  output logic                frame_err_flag,
  output logic                overrun_flag
);
  import uart_pkg::*;

  logic wr_en;
  logic ctrl_wr;
  logic clear;

  assign cfg_ready = 1'b1;  // writes never stall
  assign wr_en     = cfg_valid & cfg_ready;
  assign ctrl_wr   = wr_en & (cfg_wr.addr == ADDR_CTRL);
  assign clear     = ctrl_wr & cfg_wr.data[CTRL_CLEAR];

  // register writes, other addresses ignored
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      baud_inc <= BAUD_RESET;
      stop_two <= 1'b0;
    end else if (wr_en) begin
      case (cfg_wr.addr)
        ADDR_BAUD: baud_inc <= baud_inc_t'(cfg_wr.data);
        ADDR_CTRL: stop_two <= cfg_wr.data[CTRL_STOP_TWO];
        default:   ;
      endcase
    end
  end

  // sticky error flags
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      frame_err_flag <= 1'b0;
      overrun_flag   <= 1'b0;
    end else begin
      if (clear) begin
        frame_err_flag <= 1'b0;  // clear beats a set
      end else if (frame_err_pulse) begin
        frame_err_flag <= 1'b1;
      end

      if (clear) begin
        overrun_flag <= 1'b0;
      end else if (overrun) begin
        overrun_flag <= 1'b1;
      end
    end
  end

endmodule

// ==== logic/uart_top.sv ====
`timescale 1ns/100ps

module uart_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cfg_valid,
  output logic               cfg_ready,
  input  uart_pkg::cfg_wr_t  cfg_wr,
  input  logic               tx_valid,
  output logic               tx_ready,
  input  uart_pkg::data_t    tx_data,
  output logic               txd,
  input  logic               rxd,
  output logic               rx_valid,
  input  logic               rx_ready,
  output uart_pkg::rx_word_t rx_word,
  output logic               frame_err_flag,
  output logic               overrun_flag
);
  import uart_pkg::*;

  baud_inc_t baud_inc;
  logic      stop_two;
  logic      tick;        // shared 16x bit tick
  logic      rx_push;
  rx_word_t  push_word;
  logic      frame_err_pulse;
  logic      overrun;

  uart_cfg u_cfg (
    .clk             (clk),
    .rst_n           (rst_n),
    .cfg_valid       (cfg_valid),
    .cfg_ready       (cfg_ready),
    .cfg_wr          (cfg_wr),
    .frame_err_pulse (frame_err_pulse),
    .overrun         (overrun),
    .baud_inc        (baud_inc),
    .stop_two        (stop_two),
    .frame_err_flag  (frame_err_flag),
    .overrun_flag    (overrun_flag)
  );

  baud_gen u_baud (
    .clk      (clk),
    .rst_n    (rst_n),
    .baud_inc (baud_inc),
    .tick     (tick)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tick     (tick),
    .stop_two (stop_two),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_data  (tx_data),
    .txd      (txd)
  );

  uart_rx u_rx (
    .clk             (clk),
    .rst_n           (rst_n),
    .tick            (tick),
    .stop_two        (stop_two),
    .rxd             (rxd),
    .rx_push         (rx_push),
    .rx_word         (push_word),
    .frame_err_pulse (frame_err_pulse)
  );

  rx_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_push   (rx_push),
    .push_word (push_word),
    .rx_valid  (rx_valid),
    .rx_ready  (rx_ready),
    .rx_word   (rx_word),
    .overrun   (overrun)
  );

endmodule

// ==== uart_rx/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               tick,
  input  logic               stop_two,
  input  logic               rxd,
  output logic               rx_push,
  output uart_pkg::rx_word_t rx_word,
  output logic               frame_err_pulse
);
  import uart_pkg::*;

  localparam int TICK_W     = $clog2(OVERSAMPLE);
  localparam int CNT_W      = 8;
  localparam int POS_W      = CNT_W - TICK_W;
  localparam int STOP_EARLY = 12;  // leave 4 ticks to catch the next start edge
  localparam int END_ONE    = OVERSAMPLE * (DATA_BITS + 1) + STOP_EARLY;
  localparam int END_TWO    = OVERSAMPLE * (DATA_BITS + 2) + STOP_EARLY;

  typedef enum logic {
    RX_IDLE,
    RX_RECV
  } rx_state_e;

  rx_state_e        state;
  logic             rxd_meta;
  logic             rxd_sync;
  logic [2:0]       hist;       // last three tick samples
  logic [CNT_W-1:0] cntr;       // ticks since start edge
  logic [POS_W-1:0] bit_pos;
  logic [CNT_W-1:0] end_cnt;
  logic             new_bit;
  logic             bit_val;
  logic             ferr;
  logic             stop_two_q;
  data_t            byte_shift;

  function automatic logic vote3(input logic [2:0] s);
    return (s[0] & s[1]) | (s[0] & s[2]) | (s[1] & s[2]);
  endfunction

  assign bit_pos = cntr[CNT_W-1:TICK_W];
  assign end_cnt = stop_two_q ? CNT_W'(END_TWO) : CNT_W'(END_ONE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rxd_meta        <= 1'b1;
      rxd_sync        <= 1'b1;
      hist            <= 3'b111;
      state           <= RX_IDLE;
      cntr            <= '0;
      new_bit         <= 1'b0;
      rx_push         <= 1'b0;
      frame_err_pulse <= 1'b0;
    end else begin
      rxd_meta        <= rxd;       // two-flop sync
      rxd_sync        <= rxd_meta;
      new_bit         <= 1'b0;
      rx_push         <= 1'b0;
      frame_err_pulse <= 1'b0;

      if (tick) begin
        hist <= {hist[1:0], rxd_sync};
        if (state == RX_RECV) begin
          cntr <= cntr + 1'b1;
          if (cntr[TICK_W-1:0] == TICK_W'(OVERSAMPLE / 2)) begin  // mid bit
            new_bit <= 1'b1;
            bit_val <= vote3(hist);
          end
        end else if (!rxd_sync && hist[0]) begin  // falling edge
          state      <= RX_RECV;
          cntr       <= '0;
          ferr       <= 1'b0;
          stop_two_q <= stop_two;
        end
      end

      // act on the voted bit one cycle later
      if (new_bit) begin
        if (bit_pos == '0) begin
          if (bit_val) begin
            state <= RX_IDLE;  // glitch, not a start bit
          end
        end else if (bit_pos == POS_W'(DATA_BITS + 1)) begin
          if (!bit_val) begin
            ferr <= 1'b1;
          end
        end else if (stop_two_q && bit_pos == POS_W'(DATA_BITS + 2)) begin
          if (!bit_val) begin
            ferr <= 1'b1;
          end
        end else if (bit_pos <= POS_W'(DATA_BITS)) begin
          byte_shift <= {bit_val, byte_shift[DATA_BITS-1:1]};  // lsb first
        end
      end

      if (state == RX_RECV && cntr == end_cnt) begin
        state           <= RX_IDLE;
        cntr            <= '0;
        rx_push         <= 1'b1;
        rx_word         <= '{data: byte_shift, frame_err: ferr};
        frame_err_pulse <= ferr;
      end
    end
  end

endmodule

// ==== uart_top.f ====
common/uart_pkg.sv
logic/baud_gen.sv
uart_rx/uart_rx.sv
uart_tx/uart_tx.sv
logic/rx_fifo.sv
logic/uart_cfg.sv
logic/uart_top.sv
bench/uart_top_assertions.sv
bench/uart_top_tb.sv

// ==== uart_tx/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            tick,
  input  logic            stop_two,
  input  logic            tx_valid,
  output logic            tx_ready,
  input  uart_pkg::data_t tx_data,
  output logic            txd
);
  import uart_pkg::*;

  localparam int TICK_W = $clog2(OVERSAMPLE);
  localparam int BIT_W  = $clog2(DATA_BITS);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  tx_state_e         state;
  logic [TICK_W-1:0] tick_cnt;   // tick within current bit
  logic [BIT_W-1:0]  bit_idx;
  logic [1:0]        stop_cnt;   // stop bits already started
  logic [1:0]        stop_total;
  logic              stop_two_q;
  data_t             shift;

  assign tx_ready   = (state == TX_IDLE);
  assign stop_total = stop_two_q ? 2'd2 : 2'd1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= TX_IDLE;
      tick_cnt <= '0;
      bit_idx  <= '0;
      stop_cnt <= '0;
      txd      <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          if (tx_valid) begin
            state      <= TX_START;
            tick_cnt   <= '0;
            shift      <= tx_data;
            stop_two_q <= stop_two;  // frame keeps its own stop count
          end
        end
        TX_START: begin
          if (tick) begin
            if (tick_cnt == '0) begin
              txd <= 1'b0;
            end
            if (tick_cnt == TICK_W'(OVERSAMPLE - 1)) begin
              state   <= TX_DATA;
              bit_idx <= '0;
            end
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        TX_DATA: begin
          if (tick) begin
            if (tick_cnt == '0) begin
              txd <= shift[0];
            end
            if (tick_cnt == TICK_W'(OVERSAMPLE - 1)) begin
              shift   <= shift >> 1;
              bit_idx <= bit_idx + 1'b1;
              if (bit_idx == BIT_W'(DATA_BITS - 1)) begin
                state    <= TX_STOP;
                stop_cnt <= '0;
              end
            end
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        TX_STOP: begin
          if (tick) begin
            if (tick_cnt == '0) begin
              if (stop_cnt == stop_total) begin
                state <= TX_IDLE;  // last stop bit ends here
              end else begin
                txd      <= 1'b1;
                stop_cnt <= stop_cnt + 1'b1;
              end
            end
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule
